// ==== source/ddr3_ctrl_pkg.sv ====
`default_nettype none

package ddr3_ctrl_pkg;

  // --------------------------------------------------
  // Geometry and address map
  // --------------------------------------------------
  localparam int unsigned num_banks = 8;
  localparam int unsigned bank_w = 3;
  // Row width, also the DFI address width
  localparam int unsigned row_w = 15;
  localparam int unsigned addr_w = 32;

  // Map is row, then bank, then column
  localparam int unsigned row_lsb = 14;
  localparam int unsigned bank_lsb = 11;
  localparam int unsigned col_lsb = 4;
  localparam int unsigned col_msb = 10;
  // Column lands on DFI address bits 9 to 3
  localparam int unsigned col_dfi_lsb = 3;
  // All-banks on precharge, auto-precharge on read/write
  localparam int unsigned a10_bit = 10;

  // --------------------------------------------------
  // Commands as {cs_n, ras_n, cas_n, we_n}
  // --------------------------------------------------
  localparam logic [3:0] cmd_nop = 4'b0111;
  localparam logic [3:0] cmd_active = 4'b0011;
  localparam logic [3:0] cmd_read = 4'b0101;
  localparam logic [3:0] cmd_write = 4'b0100;
  localparam logic [3:0] cmd_precharge = 4'b0010;
  localparam logic [3:0] cmd_refresh = 4'b0001;
  localparam logic [3:0] cmd_load_mode = 4'b0000;
  localparam logic [3:0] cmd_zqcl = 4'b0110;

  // Raw code or the four active-low strobes
  typedef union packed {
    logic [3:0] code;
    struct packed {
      logic cs_n;
      logic ras_n;
      logic cas_n;
      logic we_n;
    } pins;
  } ddr_cmd_t;

  // Mode registers
  // DLL off, CL 6, AL 0, CWL 6
  localparam logic [row_w-1:0] mr0_val = 15'h0120;
  localparam logic [row_w-1:0] mr1_val = 15'h0001;
  localparam logic [row_w-1:0] mr2_val = 15'h0008;
  localparam logic [row_w-1:0] mr3_val = 15'h0000;

  // Scheduler states
  typedef enum logic [2:0] {
    state_idle = 3'd0,
    state_activate = 3'd1,
    state_read = 3'd2,
    state_write = 3'd3,
    state_precharge = 3'd4,
    state_refresh = 3'd5
  } state_t;

  // --------------------------------------------------
  // Init and refresh counts, simulation sized
  // --------------------------------------------------
  localparam int unsigned start_delay = 400;
  // CKE released once the count drops to here
  localparam int unsigned cke_release = 350;
  localparam int unsigned t_mr2 = 300;
  localparam int unsigned t_mr3 = 280;
  localparam int unsigned t_mr1 = 260;
  localparam int unsigned t_mr0 = 240;
  localparam int unsigned t_zqcl = 200;
  localparam int unsigned t_prea = 10;

  localparam int unsigned refresh_interval = 200;

  // Shared by init and refresh counters
  localparam int unsigned cnt_w = 10;

endpackage

`default_nettype wire

// ==== source/ddr3_init_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr3_init_seq (
  input  wire                              clock,
  input  wire                              reset,
  output logic                             cke_o,
  output ddr3_ctrl_pkg::ddr_cmd_t          init_cmd_o,
  output logic [ddr3_ctrl_pkg::bank_w-1:0] init_bank_o,
  output logic [ddr3_ctrl_pkg::row_w-1:0]  init_addr_o,
  output logic                             init_done_o
);
  import ddr3_ctrl_pkg::*;

  logic [cnt_w-1:0] cnt_q;
  logic             done_q;

  // --------------------------------------------------
  // Power-up countdown
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      cnt_q <= cnt_w'(start_delay);
      done_q <= 1'b0;
    end else begin
      // Count parks at zero
      if (cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // Done rises together with the count hitting zero
      if (cnt_q == cnt_w'(1)) begin
        done_q <= 1'b1;
      end
    end
  end

  assign init_done_o = done_q;

  // CKE held low through the early part of the delay
  assign cke_o = (cnt_q <= cnt_w'(cke_release));

  // --------------------------------------------------
  // Init commands at fixed counts
  // --------------------------------------------------
  always_comb begin
    init_cmd_o.code = cmd_nop;
    init_bank_o = '0;
    init_addr_o = '0;
    case (cnt_q)
      cnt_w'(t_mr2): begin
        init_cmd_o.code = cmd_load_mode;
        init_bank_o = bank_w'(2);
        init_addr_o = mr2_val;
      end
      cnt_w'(t_mr3): begin
        init_cmd_o.code = cmd_load_mode;
        init_bank_o = bank_w'(3);
        init_addr_o = mr3_val;
      end
      cnt_w'(t_mr1): begin
        init_cmd_o.code = cmd_load_mode;
        init_bank_o = bank_w'(1);
        init_addr_o = mr1_val;
      end
      cnt_w'(t_mr0): begin
        init_cmd_o.code = cmd_load_mode;
        init_bank_o = bank_w'(0);
        init_addr_o = mr0_val;
      end
      // Long ZQ calibration
      cnt_w'(t_zqcl): begin
        init_cmd_o.code = cmd_zqcl;
        init_addr_o[a10_bit] = 1'b1;
      end
      // Close every bank before handing over
      cnt_w'(t_prea): begin
        init_cmd_o.code = cmd_precharge;
        init_addr_o[a10_bit] = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/ddr3_refresh_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr3_refresh_timer (
  input  wire  clock,
  input  wire  reset,
  input  wire  enable_i,
  input  wire  refresh_done_i,
  output logic refresh_pending_o
);
  import ddr3_ctrl_pkg::*;

  logic [cnt_w-1:0] cnt_q;
  logic             tick;
  logic             pending_q;

  // Interval expired this cycle
  assign tick = enable_i && (cnt_q == '0);

  // Down-counter, one tick per refresh_interval cycles
  always_ff @(posedge clock) begin
    if (reset) begin
      cnt_q <= cnt_w'(refresh_interval - 1);
    end else if (!enable_i) begin
      // Held at reload until init completes
      cnt_q <= cnt_w'(refresh_interval - 1);
    end else if (tick) begin
      cnt_q <= cnt_w'(refresh_interval - 1);
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Pending until the scheduler has issued the refresh
  // A fresh tick wins over a same-cycle done
  always_ff @(posedge clock) begin
    if (reset) begin
      pending_q <= 1'b0;
    end else if (tick) begin
      pending_q <= 1'b1;
    end else if (refresh_done_i) begin
      pending_q <= 1'b0;
    end
  end

  assign refresh_pending_o = pending_q;

endmodule

`default_nettype wire

// ==== source/ddr3_bank_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr3_bank_tracker #(
  parameter int unsigned bank_index = 0
) (
  input  wire                             clock,
  input  wire                             reset,
  input  wire [ddr3_ctrl_pkg::bank_w-1:0] bank_i,
  input  wire [ddr3_ctrl_pkg::row_w-1:0]  row_i,
  input  wire                             activate_i,
  input  wire                             precharge_i,
  input  wire                             precharge_all_i,
  output logic                            is_open_o,
  output logic                            row_hit_o
);
  import ddr3_ctrl_pkg::*;

  logic             sel;
  logic             open_q;
  logic [row_w-1:0] row_q;

  // Strobes apply only when the request targets this bank
  assign sel = (bank_i == bank_w'(bank_index));

  // Open flag
  always_ff @(posedge clock) begin
    if (reset) begin
      open_q <= 1'b0;
    end else if (activate_i && sel) begin
      open_q <= 1'b1;
    end else if (precharge_all_i || (precharge_i && sel)) begin
      open_q <= 1'b0;
    end
  end

  // Active row, only meaningful while open
  always_ff @(posedge clock) begin
    if (activate_i && sel) begin
      row_q <= row_i;
    end
  end

  assign is_open_o = open_q;
  assign row_hit_o = open_q && (row_q == row_i);

endmodule

`default_nettype wire

// ==== source/ddr3_scheduler.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr3_scheduler (
  input  wire                                 clock,
  input  wire                                 reset,
  input  wire                                 init_done_i,
  input  wire                                 refresh_pending_i,
  output logic                                refresh_done_o,
  input  wire                                 req_valid_i,
  input  wire                                 req_write_i,
  input  wire  [ddr3_ctrl_pkg::addr_w-1:0]    req_addr_i,
  output logic                                req_accept_o,
  input  wire  [ddr3_ctrl_pkg::num_banks-1:0] bank_open_i,
  input  wire  [ddr3_ctrl_pkg::num_banks-1:0] bank_hit_i,
  output logic [ddr3_ctrl_pkg::bank_w-1:0]    req_bank_o,
  output logic [ddr3_ctrl_pkg::row_w-1:0]     req_row_o,
  output logic                                activate_o,
  output logic                                precharge_o,
  output logic                                precharge_all_o,
  output ddr3_ctrl_pkg::ddr_cmd_t             sched_cmd_o,
  output logic [ddr3_ctrl_pkg::bank_w-1:0]    sched_bank_o,
  output logic [ddr3_ctrl_pkg::row_w-1:0]     sched_addr_o
);
  import ddr3_ctrl_pkg::*;

  logic [bank_w-1:0] req_bank;
  logic [row_w-1:0]  req_row;
  logic [row_w-1:0]  req_col;
  logic              for_refresh;
  state_t            rw_state;
  state_t            state_q;
  state_t            state_d;
  state_t            target_q;
  state_t            target_d;

  // --------------------------------------------------
  // Request decode, row / bank / column
  // --------------------------------------------------
  assign req_bank = req_addr_i[bank_lsb +: bank_w];
  assign req_row = req_addr_i[row_lsb +: row_w];

  always_comb begin
    req_col = '0;
    req_col[col_dfi_lsb +: (col_msb - col_lsb + 1)] = req_addr_i[col_msb:col_lsb];
  end

  // Final state for the held request
  assign rw_state = req_write_i ? state_write : state_read;

  // --------------------------------------------------
  // Main FSM with remembered target
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    target_d = target_q;
    case (state_q)
      state_idle: begin
        if (!init_done_i) begin
          state_d = state_idle;
        end else if (refresh_pending_i) begin
          // Close open rows first, then refresh
          state_d = (|bank_open_i) ? state_precharge : state_refresh;
          target_d = state_refresh;
        end else if (req_valid_i) begin
          target_d = rw_state;
          if (bank_hit_i[req_bank]) begin
            // Row hit, straight to the access
            state_d = rw_state;
          end else if (bank_open_i[req_bank]) begin
            // Wrong row open in this bank
            state_d = state_precharge;
          end else begin
            state_d = state_activate;
          end
        end
      end
      state_activate: state_d = target_q;
      state_read: state_d = state_idle;
      state_write: state_d = state_idle;
      state_precharge: begin
        state_d = (target_q == state_refresh) ? state_refresh : state_activate;
      end
      state_refresh: state_d = state_idle;
      default: state_d = state_idle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= state_idle;
      target_q <= state_idle;
    end else begin
      state_q <= state_d;
      target_q <= target_d;
    end
  end

  // Precharge on the way to a refresh closes all banks
  assign for_refresh = (target_q == state_refresh);

  // Tracker strobes and handshakes
  assign req_bank_o = req_bank;
  assign req_row_o = req_row;
  assign activate_o = (state_q == state_activate);
  assign precharge_o = (state_q == state_precharge) && !for_refresh;
  assign precharge_all_o = (state_q == state_precharge) && for_refresh;
  assign refresh_done_o = (state_q == state_refresh);
  assign req_accept_o = (state_q == state_read) || (state_q == state_write);

  // --------------------------------------------------
  // Command per state
  // --------------------------------------------------
  always_comb begin
    sched_cmd_o.code = cmd_nop;
    sched_bank_o = '0;
    sched_addr_o = '0;
    case (state_q)
      state_activate: begin
        sched_cmd_o.code = cmd_active;
        sched_bank_o = req_bank;
        sched_addr_o = req_row;
      end
      state_read, state_write: begin
        sched_cmd_o.code = (state_q == state_write) ? cmd_write : cmd_read;
        sched_bank_o = req_bank;
        sched_addr_o = req_col;
        // No auto-precharge, row stays open
        sched_addr_o[a10_bit] = 1'b0;
      end
      state_precharge: begin
        sched_cmd_o.code = cmd_precharge;
        if (for_refresh) begin
          sched_addr_o[a10_bit] = 1'b1;
        end else begin
          sched_bank_o = req_bank;
        end
      end
      state_refresh: sched_cmd_o.code = cmd_refresh;
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/ddr3_dfi_cmd_encode.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr3_dfi_cmd_encode (
  input  wire                              clock,
  input  wire                              reset,
  input  wire                              init_done_i,
  input  wire                              cke_i,
  input  wire ddr3_ctrl_pkg::ddr_cmd_t     init_cmd_i,
  input  wire [ddr3_ctrl_pkg::bank_w-1:0]  init_bank_i,
  input  wire [ddr3_ctrl_pkg::row_w-1:0]   init_addr_i,
  input  wire ddr3_ctrl_pkg::ddr_cmd_t     sched_cmd_i,
  input  wire [ddr3_ctrl_pkg::bank_w-1:0]  sched_bank_i,
  input  wire [ddr3_ctrl_pkg::row_w-1:0]   sched_addr_i,
  output logic                             dfi_cke_o,
  output logic                             dfi_cs_n_o,
  output logic                             dfi_ras_n_o,
  output logic                             dfi_cas_n_o,
  output logic                             dfi_we_n_o,
  output logic [ddr3_ctrl_pkg::bank_w-1:0] dfi_bank_o,
  output logic [ddr3_ctrl_pkg::row_w-1:0]  dfi_address_o
);
  import ddr3_ctrl_pkg::*;

  ddr_cmd_t          cmd_d;
  ddr_cmd_t          cmd_q;
  logic [bank_w-1:0] bank_d;
  logic [row_w-1:0]  addr_d;

  // Init sequence owns the pins until done
  always_comb begin
    cmd_d.code = init_done_i ? sched_cmd_i.code : init_cmd_i.code;
    bank_d = init_done_i ? sched_bank_i : init_bank_i;
    addr_d = init_done_i ? sched_addr_i : init_addr_i;
  end

  // --------------------------------------------------
  // Pin registers, one cycle after selection
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      cmd_q.code <= cmd_nop;
      dfi_bank_o <= '0;
      dfi_address_o <= '0;
      dfi_cke_o <= 1'b0;
    end else begin
      cmd_q <= cmd_d;
      dfi_bank_o <= bank_d;
      dfi_address_o <= addr_d;
      dfi_cke_o <= cke_i;
    end
  end

  // Strobes straight from the pin view
  assign dfi_cs_n_o = cmd_q.pins.cs_n;
  assign dfi_ras_n_o = cmd_q.pins.ras_n;
  assign dfi_cas_n_o = cmd_q.pins.cas_n;
  assign dfi_we_n_o = cmd_q.pins.we_n;

endmodule

`default_nettype wire

// ==== source/ddr3_ctrl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr3_ctrl_top (
  input  wire                              clock,
  input  wire                              reset,
  input  wire                              req_valid_i,
  input  wire                              req_write_i,
  input  wire [ddr3_ctrl_pkg::addr_w-1:0]  req_addr_i,
  output logic                             req_accept_o,
  output logic                             dfi_cke_o,
  output logic                             dfi_cs_n_o,
  output logic                             dfi_ras_n_o,
  output logic                             dfi_cas_n_o,
  output logic                             dfi_we_n_o,
  output logic [ddr3_ctrl_pkg::bank_w-1:0] dfi_bank_o,
  output logic [ddr3_ctrl_pkg::row_w-1:0]  dfi_address_o
);
  import ddr3_ctrl_pkg::*;

  // Init sequencer outputs
  wire                 cke;
  wire ddr_cmd_t       init_cmd;
  wire [bank_w-1:0]    init_bank;
  wire [row_w-1:0]     init_addr;
  wire                 init_done;
  // Refresh handshake
  wire                 refresh_pending;
  wire                 refresh_done;
  // Scheduler to trackers
  wire [bank_w-1:0]    req_bank;
  wire [row_w-1:0]     req_row;
  wire                 activate;
  wire                 precharge;
  wire                 precharge_all;
  // Trackers back to scheduler
  wire [num_banks-1:0] bank_open;
  wire [num_banks-1:0] bank_hit;
  // Scheduler command
  wire ddr_cmd_t       sched_cmd;
  wire [bank_w-1:0]    sched_bank;
  wire [row_w-1:0]     sched_addr;

  ddr3_init_seq u_init_seq (
    .clock(clock), .reset(reset), .cke_o(cke), .init_cmd_o(init_cmd),
    .init_bank_o(init_bank), .init_addr_o(init_addr), .init_done_o(init_done)
  );

  ddr3_refresh_timer u_refresh_timer (
    .clock(clock), .reset(reset), .enable_i(init_done),
    .refresh_done_i(refresh_done), .refresh_pending_o(refresh_pending)
  );

  ddr3_scheduler u_scheduler (
    .clock(clock), .reset(reset), .init_done_i(init_done),
    .refresh_pending_i(refresh_pending), .refresh_done_o(refresh_done),
    .req_valid_i(req_valid_i), .req_write_i(req_write_i), .req_addr_i(req_addr_i),
    .req_accept_o(req_accept_o), .bank_open_i(bank_open), .bank_hit_i(bank_hit),
    .req_bank_o(req_bank), .req_row_o(req_row), .activate_o(activate),
    .precharge_o(precharge), .precharge_all_o(precharge_all),
    .sched_cmd_o(sched_cmd), .sched_bank_o(sched_bank), .sched_addr_o(sched_addr)
  );

  // One open-row tracker per bank
  for (genvar i = 0; i < num_banks; i++) begin : g_bank
    ddr3_bank_tracker #(.bank_index(i)) u_bank_tracker (
      .clock(clock), .reset(reset), .bank_i(req_bank), .row_i(req_row),
      .activate_i(activate), .precharge_i(precharge),
      .precharge_all_i(precharge_all), .is_open_o(bank_open[i]), .row_hit_o(bank_hit[i])
    );
  end

  ddr3_dfi_cmd_encode u_dfi_cmd_encode (
    .clock(clock), .reset(reset), .init_done_i(init_done), .cke_i(cke),
    .init_cmd_i(init_cmd), .init_bank_i(init_bank), .init_addr_i(init_addr),
    .sched_cmd_i(sched_cmd), .sched_bank_i(sched_bank), .sched_addr_i(sched_addr),
    .dfi_cke_o(dfi_cke_o), .dfi_cs_n_o(dfi_cs_n_o), .dfi_ras_n_o(dfi_ras_n_o),
    .dfi_cas_n_o(dfi_cas_n_o), .dfi_we_n_o(dfi_we_n_o), .dfi_bank_o(dfi_bank_o),
    .dfi_address_o(dfi_address_o)
  );

endmodule

`default_nettype wire

// ==== sim/ddr3_ctrl_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr3_ctrl_tb;
  import ddr3_ctrl_pkg::*;

  localparam int num_req = 150;
  localparam int watchdog_cycles = start_delay + num_req * 8 + 2000;
  // Service delay allowed on top of the refresh interval
  localparam int refresh_slack = 8;

  logic              clock = 1'b0;
  logic              reset;
  logic              req_valid;
  logic              req_write;
  logic [addr_w-1:0] req_addr;
  wire               req_accept;
  wire               dfi_cke;
  wire               dfi_cs_n;
  wire               dfi_ras_n;
  wire               dfi_cas_n;
  wire               dfi_we_n;
  wire [bank_w-1:0]  dfi_bank;
  wire [row_w-1:0]   dfi_address;

  // Scoreboard state
  int                pass_count = 0;
  int                fail_count = 0;
  int                cyc = 0;
  int                ref_cyc = 0;
  int                last_ref = start_delay + 2;
  int                refresh_count = 0;
  int                cur_len = 0;
  logic              accept_prev;
  logic              prea_prev;
  // Bank model with one open flag and row per bank
  logic              open_m [num_banks];
  logic [row_w-1:0]  row_m [num_banks];
  // Expected commands as {code, bank, address}
  logic [21:0]       exp_q [$];
  // Outstanding requests and the cycle each became visible
  logic              rq_write [$];
  logic [addr_w-1:0] rq_addr [$];
  int                rq_vis [$];
  logic [31:0]       seed = 32'hcf95;

  ddr3_ctrl_top u_dut (
    .clock(clock), .reset(reset), .req_valid_i(req_valid), .req_write_i(req_write),
    .req_addr_i(req_addr), .req_accept_o(req_accept), .dfi_cke_o(dfi_cke),
    .dfi_cs_n_o(dfi_cs_n), .dfi_ras_n_o(dfi_ras_n), .dfi_cas_n_o(dfi_cas_n),
    .dfi_we_n_o(dfi_we_n), .dfi_bank_o(dfi_bank), .dfi_address_o(dfi_address)
  );

  // 8 ns clock
  always #4 clock = ~clock;

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("ERROR %s got 0x%0h expected 0x%0h at cycle %0d", name, got, want, cyc);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("Failure at cycle %0d: %s", cyc, what);
    fail_count++;
  endtask

  task automatic report_test(input string name, input int mark);
    $display("test %-12s finished, %0d failed checks", name, fail_count - mark);
  endtask

  // Returns on the edge that completes the request
  task automatic wait_for_accept();
    do begin
      @(negedge clock);
    end while (!req_accept);
    @(posedge clock);
  endtask

  // Linear congruential step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Init command for a countdown value
  function automatic logic [21:0] init_expect(input int c);
    case (c)
      t_mr2: init_expect = {cmd_load_mode, 3'd2, mr2_val};
      t_mr3: init_expect = {cmd_load_mode, 3'd3, mr3_val};
      t_mr1: init_expect = {cmd_load_mode, 3'd1, mr1_val};
      t_mr0: init_expect = {cmd_load_mode, 3'd0, mr0_val};
      // ZQCL and precharge-all both carry A10
      t_zqcl: init_expect = {cmd_zqcl, 3'd0, 15'h0400};
      t_prea: init_expect = {cmd_precharge, 3'd0, 15'h0400};
      default: init_expect = {cmd_nop, 3'd0, 15'h0000};
    endcase
  endfunction

  // Reference sequence for one request against its bank's entry
  function automatic void build_expected(input logic is_open, input logic [row_w-1:0] open_row,
                                         input logic wr, input logic [addr_w-1:0] addr);
    logic [bank_w-1:0] bank;
    logic [row_w-1:0]  row;
    logic [row_w-1:0]  col;
    bank = addr[13:11];
    row = addr[28:14];
    col = '0;
    // Column bits 10..4 land on address 9..3
    col[9:3] = addr[10:4];
    // Miss closes the old row first
    if (is_open && open_row != row) begin
      exp_q.push_back({cmd_precharge, bank, 15'h0000});
    end
    if (!(is_open && open_row == row)) begin
      exp_q.push_back({cmd_active, bank, row});
    end
    exp_q.push_back({(wr ? cmd_write : cmd_read), bank, col});
  endfunction

  // --------------------------------------------------
  // Pin monitor and compare at mid-cycle
  // --------------------------------------------------
  always @(negedge clock) begin : monitor
    logic [3:0]        code;
    logic [21:0]       want;
    logic              is_rw;
    logic              is_prea;
    logic [addr_w-1:0] head_addr;
    int                n_open;
    int                lat;
    if (reset) begin
      cyc = 0;
      accept_prev = 1'b0;
      prea_prev = 1'b0;
      for (int b = 0; b < num_banks; b++) begin
        open_m[b] = 1'b0;
      end
    end else begin
      cyc++;
      code = {dfi_cs_n, dfi_ras_n, dfi_cas_n, dfi_we_n};
      if (cyc <= start_delay + 1) begin
        // Pins trail the countdown by one cycle
        want = init_expect(start_delay + 2 - cyc);
        compare_value("dfi_cke", dfi_cke, (start_delay + 2 - cyc) <= cke_release);
        compare_value("dfi_cmd", code, want[21:18]);
        compare_value("dfi_bank", dfi_bank, want[17:15]);
        compare_value("dfi_address", dfi_address, want[14:0]);
        compare_value("req_accept", req_accept, 1'b0);
      end else begin
        is_rw = (code == cmd_read) || (code == cmd_write);
        is_prea = (code == cmd_precharge) && dfi_address[a10_bit];
        compare_value("dfi_cke", dfi_cke, 1'b1);
        // Access on the pins exactly one cycle after accept
        compare_value("req_accept", accept_prev, is_rw);
        if (prea_prev) begin
          compare_value("dfi_cmd", code, cmd_refresh);
        end
        prea_prev = is_prea;
        if (code == cmd_refresh) begin
          // Refresh carries zero bank and address
          compare_value("dfi_bank", dfi_bank, 0);
          compare_value("dfi_address", dfi_address, 0);
          n_open = 0;
          for (int b = 0; b < num_banks; b++) begin
            if (open_m[b]) begin
              n_open++;
            end
          end
          // Precharge-all must have closed everything
          compare_value("open_banks", n_open, 0);
          if (cyc - last_ref > refresh_interval + refresh_slack) begin
            report_problem("refresh came later than one refresh interval");
          end
          refresh_count++;
          last_ref = cyc;
          ref_cyc = cyc;
        end else if (is_prea) begin
          compare_value("dfi_address", dfi_address, 32'h1 << a10_bit);
          for (int b = 0; b < num_banks; b++) begin
            open_m[b] = 1'b0;
          end
        end else if (code != cmd_nop) begin
          if (exp_q.size() == 0) begin
            if (rq_addr.size() == 0) begin
              report_problem("command issued with no request outstanding");
            end else begin
              head_addr = rq_addr[0];
              build_expected(open_m[head_addr[13:11]], row_m[head_addr[13:11]],
                             rq_write[0], head_addr);
              cur_len = exp_q.size();
            end
          end
          if (exp_q.size() != 0) begin
            want = exp_q.pop_front();
            compare_value("dfi_cmd", code, want[21:18]);
            compare_value("dfi_bank", dfi_bank, want[17:15]);
            compare_value("dfi_address", dfi_address, want[14:0]);
          end
          // Model follows the pins
          if (code == cmd_active) begin
            open_m[dfi_bank] = 1'b1;
            row_m[dfi_bank] = dfi_address;
          end else if (code == cmd_precharge) begin
            open_m[dfi_bank] = 1'b0;
          end
          if (is_rw && rq_addr.size() != 0) begin
            lat = cyc - rq_vis[0] - 1;
            // A refresh in the wait stretches latency
            if (ref_cyc < rq_vis[0]) begin
              compare_value("latency", lat, cur_len);
            end
            void'(rq_write.pop_front());
            void'(rq_addr.pop_front());
            void'(rq_vis.pop_front());
          end
        end
      end
      accept_prev = req_accept;
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : stimulus
    int                mark;
    int                rc;
    logic [31:0]       r;
    logic [addr_w-1:0] addr;
    reset = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr = '0;
    repeat (3) @(posedge clock);
    reset <= 1'b0;

    // Request held through the whole init countdown
    mark = fail_count;
    addr = '0;
    addr[28:14] = 15'h0123;
    addr[13:11] = 3'd5;
    addr[10:4] = 7'h2a;
    req_valid <= 1'b1;
    req_write <= 1'b1;
    req_addr <= addr;
    rq_write.push_back(1'b1);
    rq_addr.push_back(addr);
    // First cycle with init done
    rq_vis.push_back(start_delay + 1);
    while (cyc <= start_delay + 1) @(posedge clock);
    wait_for_accept();
    req_valid <= 1'b0;
    report_test("init", mark);

    // Nothing requested so pins stay NOP
    mark = fail_count;
    repeat (40) @(posedge clock);
    report_test("idle", mark);

    mark = fail_count;
    for (int i = 0; i < num_req; i++) begin
      seed = lcg_next(seed);
      r = seed;
      // Rows 0..3 in banks 0..3 so hits and misses both occur
      addr = '0;
      addr[28:14] = row_w'(r[31:30]);
      addr[13:11] = r[29:28];
      addr[10:4] = r[27:21];
      addr[3:0] = r[17:14];
      if (r[19:18] != 2'd0) begin
        req_valid <= 1'b0;
        repeat (r[19:18]) @(posedge clock);
      end
      req_valid <= 1'b1;
      req_write <= r[20];
      req_addr <= addr;
      rq_write.push_back(r[20]);
      rq_addr.push_back(addr);
      rq_vis.push_back(cyc + 1);
      // Held until accept
      wait_for_accept();
    end
    req_valid <= 1'b0;
    report_test("row_policy", mark);

    // Wait for the next periodic refresh
    mark = fail_count;
    rc = refresh_count;
    while (refresh_count == rc) @(posedge clock);
    repeat (4) @(posedge clock);
    if (refresh_count < (cyc - start_delay - 2 - refresh_slack) / refresh_interval) begin
      report_problem("fewer refreshes than the elapsed time needs");
    end
    report_test("refresh", mark);

    if (rq_addr.size() != 0 || exp_q.size() != 0) begin
      report_problem("request left without its read or write");
    end
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clock);
    $display("Run timed out after %0d cycles before the tests completed", watchdog_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/ddr3_ctrl_pkg.sv
source/ddr3_init_seq.sv
source/ddr3_refresh_timer.sv
source/ddr3_bank_tracker.sv
source/ddr3_scheduler.sv
source/ddr3_dfi_cmd_encode.sv
source/ddr3_ctrl_top.sv
sim/ddr3_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DDR3 scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log && \
verilator --binary --timing -Wno-fatal --top-module ddr3_ctrl_tb \
  -f filelist.f -o ddr3_ctrl_sim && \
./obj_dir/ddr3_ctrl_sim | tee sim.log || \
{ echo "build or run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1
